// File: source/osc_pkg.sv
`default_nettype none

package osc_pkg;

  // s1.16 fixed point, shared by coefficients, states and products
  typedef logic signed [17:0] fix_t;

  localparam int FIX_FRAC = 16;
  localparam int DT_SHIFT = 9;     // dt = 2^-9

  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [AXI_DATA_W-1:0] STEP_DIV_MIN = 32'd4; // plotter needs 4 cycles per step

  localparam logic [AXI_ADDR_W-1:0] REG_CTRL     = 8'h00; // bit 0 run, bit 1 load
  localparam logic [AXI_ADDR_W-1:0] REG_STEP_DIV = 8'h04;
  localparam logic [AXI_ADDR_W-1:0] REG_K1       = 8'h08;
  localparam logic [AXI_ADDR_W-1:0] REG_K2       = 8'h0C;
  localparam logic [AXI_ADDR_W-1:0] REG_KMID     = 8'h10;
  localparam logic [AXI_ADDR_W-1:0] REG_G1       = 8'h14;
  localparam logic [AXI_ADDR_W-1:0] REG_G2       = 8'h18;
  localparam logic [AXI_ADDR_W-1:0] REG_X1_INIT  = 8'h1C;
  localparam logic [AXI_ADDR_W-1:0] REG_X2_INIT  = 8'h20;
  localparam logic [AXI_ADDR_W-1:0] REG_V1_INIT  = 8'h24;
  localparam logic [AXI_ADDR_W-1:0] REG_V2_INIT  = 8'h28;
  localparam logic [AXI_ADDR_W-1:0] REG_X1       = 8'h2C; // read only
  localparam logic [AXI_ADDR_W-1:0] REG_X2       = 8'h30; // read only
  localparam logic [AXI_ADDR_W-1:0] REG_STEPS    = 8'h34; // read only

endpackage

`default_nettype wire

// File: source/plot_pkg.sv
`default_nettype none

package plot_pkg;

  typedef logic [9:0] col_t;
  typedef logic [8:0] row_t;

  localparam col_t SCREEN_W = 10'd640;

  // centre rows of the two traces
  localparam row_t X1_BASE_ROW = 9'd120;
  localparam row_t X2_BASE_ROW = 9'd360;

  // position bits that give the signed row offset
  localparam int TRACE_MSB = 17;
  localparam int TRACE_LSB = 13;

endpackage

`default_nettype wire

// File: source/osc_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module osc_axil_regs (
  input  wire                                AnalogClock,
  input  wire                                arst_n,
  input  wire [osc_pkg::AXI_ADDR_W-1:0]      s_awaddr,
  input  wire                                s_awvalid,
  output logic                               s_awready,
  input  wire [osc_pkg::AXI_DATA_W-1:0]      s_wdata,
  input  wire [osc_pkg::AXI_DATA_W/8-1:0]    s_wstrb,
  input  wire                                s_wvalid,
  output logic                               s_wready,
  output logic [1:0]                         s_bresp,
  output logic                               s_bvalid,
  input  wire                                s_bready,
  input  wire [osc_pkg::AXI_ADDR_W-1:0]      s_araddr,
  input  wire                                s_arvalid,
  output logic                               s_arready,
  output logic [osc_pkg::AXI_DATA_W-1:0]     s_rdata,
  output logic [1:0]                         s_rresp,
  output logic                               s_rvalid,
  input  wire                                s_rready,
  output osc_pkg::fix_t                      k1,
  output osc_pkg::fix_t                      k2,
  output osc_pkg::fix_t                      kmid,
  output osc_pkg::fix_t                      g1,
  output osc_pkg::fix_t                      g2,
  output osc_pkg::fix_t                      x1_init,
  output osc_pkg::fix_t                      x2_init,
  output osc_pkg::fix_t                      v1_init,
  output osc_pkg::fix_t                      v2_init,
  output logic                               load,
  output logic                               step,
  input  wire osc_pkg::fix_t                 x1,
  input  wire osc_pkg::fix_t                 x2,
  input  wire                                plotter_busy
);

  localparam int DW = osc_pkg::AXI_DATA_W;

  logic          run;
  logic [DW-1:0] step_div;
  logic [DW-1:0] div_limit;
  logic [DW-1:0] div_cnt;
  logic [DW-1:0] steps;
  logic          wr_en;
  logic          wr_full;
  logic          wr_err;
  logic          rd_en;
  logic          rd_err;
  logic [DW-1:0] rd_word;

  function automatic logic [DW-1:0] sext(input osc_pkg::fix_t v);
    return {{(DW - $bits(osc_pkg::fix_t)){v[$bits(osc_pkg::fix_t)-1]}}, v};
  endfunction

  // address and data taken together, one write in flight
  assign wr_en     = s_awvalid && s_wvalid && !s_bvalid;
  assign s_awready = wr_en;
  assign s_wready  = wr_en;
  assign wr_full   = &s_wstrb;    // partial words are ignored

  assign s_arready = !s_rvalid;
  assign rd_en     = s_arvalid && !s_rvalid;

  always_comb
  begin
    case (s_awaddr)
      osc_pkg::REG_CTRL, osc_pkg::REG_STEP_DIV, osc_pkg::REG_K1, osc_pkg::REG_K2,
      osc_pkg::REG_KMID, osc_pkg::REG_G1, osc_pkg::REG_G2, osc_pkg::REG_X1_INIT,
      osc_pkg::REG_X2_INIT, osc_pkg::REG_V1_INIT, osc_pkg::REG_V2_INIT,
      osc_pkg::REG_X1, osc_pkg::REG_X2, osc_pkg::REG_STEPS: wr_err = 1'b0;
      default: wr_err = 1'b1;
    endcase
  end

  always_ff @(posedge AnalogClock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      run      <= 1'b0;
      step_div <= osc_pkg::STEP_DIV_MIN;
      k1       <= '0;
      k2       <= '0;
      kmid     <= '0;
      g1       <= '0;
      g2       <= '0;
      x1_init  <= '0;
      x2_init  <= '0;
      v1_init  <= '0;
      v2_init  <= '0;
    end
    else if (wr_en && wr_full)
    begin
      case (s_awaddr)
        osc_pkg::REG_CTRL:     run      <= s_wdata[0];
        osc_pkg::REG_STEP_DIV: step_div <= s_wdata;
        osc_pkg::REG_K1:       k1       <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_K2:       k2       <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_KMID:     kmid     <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_G1:       g1       <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_G2:       g2       <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_X1_INIT:  x1_init  <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_X2_INIT:  x2_init  <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_V1_INIT:  v1_init  <= osc_pkg::fix_t'(s_wdata[17:0]);
        osc_pkg::REG_V2_INIT:  v2_init  <= osc_pkg::fix_t'(s_wdata[17:0]);
        default: ;  // read only or unmapped
      endcase
    end
  end

  always_ff @(posedge AnalogClock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      load     <= 1'b0;
      s_bvalid <= 1'b0;
      s_bresp  <= osc_pkg::RESP_OKAY;
    end
    else
    begin
      load <= wr_en && wr_full && (s_awaddr == osc_pkg::REG_CTRL) && s_wdata[1]; // self clearing
      if (wr_en)
      begin
        s_bvalid <= 1'b1;
        s_bresp  <= wr_err ? osc_pkg::RESP_SLVERR : osc_pkg::RESP_OKAY;
      end
      else if (s_bready)
        s_bvalid <= 1'b0;
    end
  end

  always_comb
  begin
    rd_err  = 1'b0;
    rd_word = '0;
    case (s_araddr)
      osc_pkg::REG_CTRL:     rd_word = {{(DW-1){1'b0}}, run}; // load reads as 0
      osc_pkg::REG_STEP_DIV: rd_word = step_div;
      osc_pkg::REG_K1:       rd_word = sext(k1);
      osc_pkg::REG_K2:       rd_word = sext(k2);
      osc_pkg::REG_KMID:     rd_word = sext(kmid);
      osc_pkg::REG_G1:       rd_word = sext(g1);
      osc_pkg::REG_G2:       rd_word = sext(g2);
      osc_pkg::REG_X1_INIT:  rd_word = sext(x1_init);
      osc_pkg::REG_X2_INIT:  rd_word = sext(x2_init);
      osc_pkg::REG_V1_INIT:  rd_word = sext(v1_init);
      osc_pkg::REG_V2_INIT:  rd_word = sext(v2_init);
      osc_pkg::REG_X1:       rd_word = sext(x1);
      osc_pkg::REG_X2:       rd_word = sext(x2);
      osc_pkg::REG_STEPS:    rd_word = steps;
      default:               rd_err  = 1'b1;
    endcase
  end

  always_ff @(posedge AnalogClock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s_rvalid <= 1'b0;
      s_rdata  <= '0;
      s_rresp  <= osc_pkg::RESP_OKAY;
    end
    else if (rd_en)
    begin
      s_rvalid <= 1'b1;
      s_rdata  <= rd_word;
      s_rresp  <= rd_err ? osc_pkg::RESP_SLVERR : osc_pkg::RESP_OKAY;
    end
    else if (s_rready)
      s_rvalid <= 1'b0;
  end

  // step divider, held off while the plotter still draws
  assign div_limit = (step_div < osc_pkg::STEP_DIV_MIN) ? osc_pkg::STEP_DIV_MIN : step_div;

  always_ff @(posedge AnalogClock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      div_cnt <= '0;
      step    <= 1'b0;
    end
    else if (!run)
    begin
      div_cnt <= '0;
      step    <= 1'b0;
    end
    else if ((div_cnt >= div_limit - 1'b1) && !plotter_busy)
    begin
      div_cnt <= '0;
      step    <= 1'b1;
    end
    else
    begin
      step <= 1'b0;
      if (div_cnt < div_limit - 1'b1)
        div_cnt <= div_cnt + 1'b1; // saturates while waiting on plotter
    end
  end

  always_ff @(posedge AnalogClock or negedge arst_n)
  begin
    if (!arst_n)
      steps <= '0;
    else if (load)
      steps <= '0;
    else if (step)
      steps <= steps + 1'b1;
  end

endmodule

`default_nettype wire

// File: source/euler_integrator.sv
`timescale 1ns/1ps
`default_nettype none

module euler_integrator (
  input  wire                AnalogClock,
  input  wire                arst_n,
  input  wire                load,
  input  wire                step,
  input  wire osc_pkg::fix_t init_value,
  input  wire osc_pkg::fix_t deriv,
  output osc_pkg::fix_t      state
);

  localparam int W = $bits(osc_pkg::fix_t);

  osc_pkg::fix_t      d_scaled;
  logic signed [W:0]  sum;          // one guard bit for overflow
  osc_pkg::fix_t      sum_sat;

  assign d_scaled = deriv >>> osc_pkg::DT_SHIFT;   // deriv * dt
  assign sum      = {state[W-1], state} + {d_scaled[W-1], d_scaled};

  always_comb
  begin
    if (sum[W] != sum[W-1])
      sum_sat = sum[W] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
    else
      sum_sat = sum[W-1:0];
  end

  always_ff @(posedge AnalogClock or negedge arst_n)
  begin
    if (!arst_n)
      state <= '0;
    else if (load)
      state <= init_value;   // load beats step
    else if (step)
      state <= sum_sat;
  end

endmodule

`default_nettype wire

// File: source/oscillator_core.sv
`timescale 1ns/1ps
`default_nettype none

module oscillator_core (
  input  wire                AnalogClock,
  input  wire                arst_n,
  input  wire                load,
  input  wire                step,
  input  wire osc_pkg::fix_t k1,
  input  wire osc_pkg::fix_t k2,
  input  wire osc_pkg::fix_t kmid,
  input  wire osc_pkg::fix_t g1,
  input  wire osc_pkg::fix_t g2,
  input  wire osc_pkg::fix_t x1_init,
  input  wire osc_pkg::fix_t x2_init,
  input  wire osc_pkg::fix_t v1_init,
  input  wire osc_pkg::fix_t v2_init,
  output osc_pkg::fix_t      x1,
  output osc_pkg::fix_t      x2
);

  osc_pkg::fix_t v1;
  osc_pkg::fix_t v2;
  osc_pkg::fix_t dx21;
  osc_pkg::fix_t dx12;
  osc_pkg::fix_t a1;
  osc_pkg::fix_t a2;

  // s1.16 times s1.16, drop the low fraction bits
  function automatic osc_pkg::fix_t fmul(input osc_pkg::fix_t a, input osc_pkg::fix_t b);
    logic signed [2*$bits(osc_pkg::fix_t)-1:0] p;
    p = a * b;
    return p[osc_pkg::FIX_FRAC +: $bits(osc_pkg::fix_t)];
  endfunction

  assign dx21 = x2 - x1;
  assign dx12 = x1 - x2;

  // accelerations from the registered state, sums wrap
  assign a1 = fmul(kmid, dx21) + fmul(k1, x1) + fmul(g1, v1);
  assign a2 = fmul(kmid, dx12) + fmul(k2, x2) + fmul(g2, v2);

  euler_integrator u_v1 (
    .AnalogClock (AnalogClock),
    .arst_n      (arst_n),
    .load        (load),
    .step        (step),
    .init_value  (v1_init),
    .deriv       (a1),
    .state       (v1)
  );

  euler_integrator u_v2 (
    .AnalogClock (AnalogClock),
    .arst_n      (arst_n),
    .load        (load),
    .step        (step),
    .init_value  (v2_init),
    .deriv       (a2),
    .state       (v2)
  );

  euler_integrator u_x1 (
    .AnalogClock (AnalogClock),
    .arst_n      (arst_n),
    .load        (load),
    .step        (step),
    .init_value  (x1_init),
    .deriv       (v1),        // old v1, updated in the same step
    .state       (x1)
  );

  euler_integrator u_x2 (
    .AnalogClock (AnalogClock),
    .arst_n      (arst_n),
    .load        (load),
    .step        (step),
    .init_value  (x2_init),
    .deriv       (v2),
    .state       (x2)
  );

endmodule

`default_nettype wire

// File: source/trace_plotter.sv
`timescale 1ns/1ps
`default_nettype none

module trace_plotter (
  input  wire                AnalogClock,
  input  wire                arst_n,
  input  wire                step,
  input  wire osc_pkg::fix_t x1,
  input  wire osc_pkg::fix_t x2,
  output logic               pix_valid,
  input  wire                pix_ready,
  output plot_pkg::col_t     pix_x,
  output plot_pkg::row_t     pix_y,
  output logic               pix_trace,   // 0 for x1, 1 for x2
  output logic               plotter_busy
);

  localparam int OFF_W = plot_pkg::TRACE_MSB - plot_pkg::TRACE_LSB + 1;
  localparam int ROW_W = $bits(plot_pkg::row_t);

  typedef enum logic [1:0] {S_IDLE, S_X1, S_X2} state_t;

  state_t         state;
  logic           step_d;     // first cycle after a step
  plot_pkg::col_t col;
  plot_pkg::row_t y1_now;
  plot_pkg::row_t y2_now;
  plot_pkg::row_t y1_q;
  plot_pkg::row_t y2_q;

  function automatic plot_pkg::row_t row_of(input plot_pkg::row_t base, input osc_pkg::fix_t pos);
    logic [OFF_W-1:0] off;
    off = pos[plot_pkg::TRACE_MSB:plot_pkg::TRACE_LSB];
    return base + {{(ROW_W-OFF_W){off[OFF_W-1]}}, off};
  endfunction

  assign y1_now = row_of(plot_pkg::X1_BASE_ROW, x1);
  assign y2_now = row_of(plot_pkg::X2_BASE_ROW, x2);

  always_ff @(posedge AnalogClock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state  <= S_IDLE;
      step_d <= 1'b0;
      col    <= '0;
    end
    else
    begin
      step_d <= step;
      case (state)
        S_IDLE:
          if (step)
            state <= S_X1;
        S_X1:
          if (pix_ready)
            state <= S_X2;
        S_X2:
          if (pix_ready)
          begin
            state <= S_IDLE;
            col   <= (col == plot_pkg::SCREEN_W - 1'b1) ? '0 : col + 1'b1; // wrap
          end
        default: state <= S_IDLE;
      endcase
    end
  end

  // new state is visible right after the step, hold it for the pixels
  always_ff @(posedge AnalogClock)
  begin
    if (step_d)
    begin
      y1_q <= y1_now;
      y2_q <= y2_now;
    end
  end

  assign pix_valid    = (state != S_IDLE);
  assign pix_trace    = (state == S_X2);
  assign pix_x        = col;
  assign pix_y        = (state == S_X2) ? y2_q : (step_d ? y1_now : y1_q);
  assign plotter_busy = step || (state != S_IDLE);

endmodule

`default_nettype wire

// File: source/eulersillator_top.sv
`timescale 1ns/1ps
`default_nettype none

module eulersillator_top (
  input  wire                             AnalogClock,
  input  wire                             arst_n,
  input  wire [osc_pkg::AXI_ADDR_W-1:0]   s_awaddr,
  input  wire                             s_awvalid,
  output wire                             s_awready,
  input  wire [osc_pkg::AXI_DATA_W-1:0]   s_wdata,
  input  wire [osc_pkg::AXI_DATA_W/8-1:0] s_wstrb,
  input  wire                             s_wvalid,
  output wire                             s_wready,
  output wire [1:0]                       s_bresp,
  output wire                             s_bvalid,
  input  wire                             s_bready,
  input  wire [osc_pkg::AXI_ADDR_W-1:0]   s_araddr,
  input  wire                             s_arvalid,
  output wire                             s_arready,
  output wire [osc_pkg::AXI_DATA_W-1:0]   s_rdata,
  output wire [1:0]                       s_rresp,
  output wire                             s_rvalid,
  input  wire                             s_rready,
  output wire                             pix_valid,
  input  wire                             pix_ready,
  output wire plot_pkg::col_t             pix_x,
  output wire plot_pkg::row_t             pix_y,
  output wire                             pix_trace
);

  wire osc_pkg::fix_t k1;
  wire osc_pkg::fix_t k2;
  wire osc_pkg::fix_t kmid;
  wire osc_pkg::fix_t g1;
  wire osc_pkg::fix_t g2;
  wire osc_pkg::fix_t x1_init;
  wire osc_pkg::fix_t x2_init;
  wire osc_pkg::fix_t v1_init;
  wire osc_pkg::fix_t v2_init;
  wire osc_pkg::fix_t x1;
  wire osc_pkg::fix_t x2;
  wire                load;
  wire                step;
  wire                plotter_busy;

  osc_axil_regs u_regs (
    .AnalogClock  (AnalogClock),
    .arst_n       (arst_n),
    .s_awaddr     (s_awaddr),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .s_wdata      (s_wdata),
    .s_wstrb      (s_wstrb),
    .s_wvalid     (s_wvalid),
    .s_wready     (s_wready),
    .s_bresp      (s_bresp),
    .s_bvalid     (s_bvalid),
    .s_bready     (s_bready),
    .s_araddr     (s_araddr),
    .s_arvalid    (s_arvalid),
    .s_arready    (s_arready),
    .s_rdata      (s_rdata),
    .s_rresp      (s_rresp),
    .s_rvalid     (s_rvalid),
    .s_rready     (s_rready),
    .k1           (k1),
    .k2           (k2),
    .kmid         (kmid),
    .g1           (g1),
    .g2           (g2),
    .x1_init      (x1_init),
    .x2_init      (x2_init),
    .v1_init      (v1_init),
    .v2_init      (v2_init),
    .load         (load),
    .step         (step),
    .x1           (x1),
    .x2           (x2),
    .plotter_busy (plotter_busy)
  );

  oscillator_core u_core (
    .AnalogClock (AnalogClock),
    .arst_n      (arst_n),
    .load        (load),
    .step        (step),
    .k1          (k1),
    .k2          (k2),
    .kmid        (kmid),
    .g1          (g1),
    .g2          (g2),
    .x1_init     (x1_init),
    .x2_init     (x2_init),
    .v1_init     (v1_init),
    .v2_init     (v2_init),
    .x1          (x1),
    .x2          (x2)
  );

  trace_plotter u_plot (
    .AnalogClock  (AnalogClock),
    .arst_n       (arst_n),
    .step         (step),
    .x1           (x1),
    .x2           (x2),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .pix_x        (pix_x),
    .pix_y        (pix_y),
    .pix_trace    (pix_trace),
    .plotter_busy (plotter_busy)
  );

endmodule

`default_nettype wire

// File: verification/eulersillator_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eulersillator_checker (
  input wire                 AnalogClock,
  input wire                 arst_n,
  input wire                 pix_valid,
  input wire                 pix_ready,
  input wire plot_pkg::col_t pix_x,
  input wire plot_pkg::row_t pix_y,
  input wire                 pix_trace,
  input wire                 s_bvalid,
  input wire                 s_bready,
  input wire [1:0]           s_bresp,
  input wire                 s_rvalid,
  input wire                 s_rready,
  input wire [31:0]          s_rdata,
  input wire                 step
);

  int fail_cnt = 0;   // read by the testbench

  // pixel held under back-pressure
  pix_hold: assert property (@(posedge AnalogClock) disable iff (!arst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix_x) && $stable(pix_y)
                                && $stable(pix_trace))
    else
    begin
      fail_cnt++;
      $error("pixel dropped or changed before pix_ready");
    end

  b_hold: assert property (@(posedge AnalogClock) disable iff (!arst_n)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
    else
    begin
      fail_cnt++;
      $error("write response dropped before s_bready");
    end

  r_hold: assert property (@(posedge AnalogClock) disable iff (!arst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else
    begin
      fail_cnt++;
      $error("read response dropped before s_rready");
    end

  // step is issued only from an idle plotter
  step_free: assert property (@(posedge AnalogClock) disable iff (!arst_n)
    step |-> !pix_valid)
    else
    begin
      fail_cnt++;
      $error("step issued while the plotter still had a pixel");
    end

endmodule

bind eulersillator_top eulersillator_checker u_checker (
  .AnalogClock  (AnalogClock),
  .arst_n       (arst_n),
  .pix_valid    (pix_valid),
  .pix_ready    (pix_ready),
  .pix_x        (pix_x),
  .pix_y        (pix_y),
  .pix_trace    (pix_trace),
  .s_bvalid     (s_bvalid),
  .s_bready     (s_bready),
  .s_bresp      (s_bresp),
  .s_rvalid     (s_rvalid),
  .s_rready     (s_rready),
  .s_rdata      (s_rdata),
  .step         (step)
);

`default_nettype wire

// File: verification/eulersillator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eulersillator_tb;

  localparam int TIMEOUT_CYCLES = 20000; // 700 steps of ~7 cycles each plus bus traffic
  localparam int RUN_STEPS      = 700;   // enough to wrap the 640 columns
  localparam logic [31:0] DIV   = 32'd6;
  localparam logic [7:0] BAD_ADDR = 8'h40;

  // springs pull back and coupling pulls together with light damping
  localparam logic signed [17:0] K1      = -18'sd65536;  // -1.0
  localparam logic signed [17:0] K2      = -18'sd81920;  // -1.25
  localparam logic signed [17:0] KMID    = 18'sd32768;   // 0.5
  localparam logic signed [17:0] G1      = -18'sd1311;
  localparam logic signed [17:0] G2      = -18'sd655;
  localparam logic signed [17:0] X1_INIT = 18'sd58982;   // 0.9
  localparam logic signed [17:0] X2_INIT = -18'sd19661;  // -0.3
  localparam logic signed [17:0] V1_INIT = -18'sd6554;   // -0.1
  localparam logic signed [17:0] V2_INIT = 18'sd13107;   // 0.2

  logic        AnalogClock;
  logic        arst_n;
  logic [7:0]  s_awaddr;
  logic        s_awvalid;
  logic [31:0] s_wdata;
  logic [3:0]  s_wstrb;
  logic        s_wvalid;
  logic        s_bready;
  logic [7:0]  s_araddr;
  logic        s_arvalid;
  logic        s_rready;
  logic        pix_ready;
  wire         s_awready;
  wire         s_wready;
  wire  [1:0]  s_bresp;
  wire         s_bvalid;
  wire         s_arready;
  wire  [31:0] s_rdata;
  wire  [1:0]  s_rresp;
  wire         s_rvalid;
  wire         pix_valid;
  wire  [9:0]  pix_x;
  wire  [8:0]  pix_y;
  wire         pix_trace;

  logic signed [17:0] m_x1;   // reference state
  logic signed [17:0] m_x2;
  logic signed [17:0] m_v1;
  logic signed [17:0] m_v2;
  int     exp_col   = 0;
  logic   want_x2   = 1'b0;
  int     pix_count = 0;
  int     err_cnt   = 0;
  int     cycle_cnt = 0;
  integer seed      = 32'h605b4a62;

  eulersillator_top UUT (
    .AnalogClock (AnalogClock),
    .arst_n      (arst_n),
    .s_awaddr    (s_awaddr),
    .s_awvalid   (s_awvalid),
    .s_awready   (s_awready),
    .s_wdata     (s_wdata),
    .s_wstrb     (s_wstrb),
    .s_wvalid    (s_wvalid),
    .s_wready    (s_wready),
    .s_bresp     (s_bresp),
    .s_bvalid    (s_bvalid),
    .s_bready    (s_bready),
    .s_araddr    (s_araddr),
    .s_arvalid   (s_arvalid),
    .s_arready   (s_arready),
    .s_rdata     (s_rdata),
    .s_rresp     (s_rresp),
    .s_rvalid    (s_rvalid),
    .s_rready    (s_rready),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .pix_trace   (pix_trace)
  );

  initial
  begin
    AnalogClock = 1'b0;
    forever #20 AnalogClock = ~AnalogClock;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  // floor of the s1.16 product wrapped to 18 bits
  function automatic logic signed [17:0] fxmul(input logic signed [17:0] a,
                                               input logic signed [17:0] b);
    longint p;
    p = longint'(a) * longint'(b);
    p = p >>> osc_pkg::FIX_FRAC;
    return p[17:0];
  endfunction

  function automatic logic signed [17:0] sat_add(input logic signed [17:0] s,
                                                 input logic signed [17:0] d);
    longint t;
    t = longint'(s) + (longint'(d) >>> osc_pkg::DT_SHIFT);
    if (t > 131071)
      t = 131071;
    else if (t < -131072)
      t = -131072;
    return t[17:0];
  endfunction

  // one Euler step with every term from the old state
  function automatic logic [71:0] next_state(input logic signed [17:0] x1,
                                             input logic signed [17:0] x2,
                                             input logic signed [17:0] v1,
                                             input logic signed [17:0] v2);
    logic signed [17:0] a1;
    logic signed [17:0] a2;
    a1 = fxmul(KMID, x2 - x1) + fxmul(K1, x1) + fxmul(G1, v1);
    a2 = fxmul(KMID, x1 - x2) + fxmul(K2, x2) + fxmul(G2, v2);
    return {sat_add(x1, v1), sat_add(x2, v2), sat_add(v1, a1), sat_add(v2, a2)};
  endfunction

  function automatic logic [8:0] row_for(input int base, input logic signed [17:0] pos);
    int r;
    r = base + int'(pos >>> plot_pkg::TRACE_LSB);  // top five bits as signed offset
    return r[8:0];
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    @(negedge AnalogClock);
    s_awaddr  = addr;
    s_awvalid = 1'b1;
    s_wdata   = data;
    s_wstrb   = strb;
    s_wvalid  = 1'b1;
    s_bready  = 1'b1;
    @(posedge AnalogClock);
    while (!s_awready)
      @(posedge AnalogClock);
    @(negedge AnalogClock);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    while (!s_bvalid)
      @(negedge AnalogClock);
    resp = s_bresp;
    @(negedge AnalogClock);
    s_bready = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge AnalogClock);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    s_rready  = 1'b1;
    @(posedge AnalogClock);
    while (!s_arready)
      @(posedge AnalogClock);
    @(negedge AnalogClock);
    s_arvalid = 1'b0;
    while (!s_rvalid)
      @(negedge AnalogClock);
    data = s_rdata;
    resp = s_rresp;
    @(negedge AnalogClock);
    s_rready = 1'b0;
  endtask

  task automatic expect_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(addr, data, resp);
    compare({name, " rresp"}, 32'(resp), 32'(osc_pkg::RESP_OKAY));
    compare(name, data, exp);
  endtask

  task automatic program_reg(input string name, input logic [7:0] addr, input logic [31:0] val);
    logic [1:0] resp;
    write_reg(addr, val, 4'hf, resp);
    compare({name, " bresp"}, 32'(resp), 32'(osc_pkg::RESP_OKAY));
    expect_reg(name, addr, val);
  endtask

  // random back-pressure on about one cycle in four
  always @(negedge AnalogClock)
    pix_ready = (($random(seed) & 3) != 0);

  // pixel sink that checks each accepted pixel against the model
  always @(posedge AnalogClock)
  begin
    if (arst_n && pix_valid && pix_ready)
    begin
      compare("pix_trace", 32'(pix_trace), 32'(want_x2));
      compare("pix_x", 32'(pix_x), 32'(exp_col));
      if (!want_x2)
      begin
        {m_x1, m_x2, m_v1, m_v2} = next_state(m_x1, m_x2, m_v1, m_v2);
        compare("pix_y x1", 32'(pix_y), 32'(row_for(plot_pkg::X1_BASE_ROW, m_x1)));
      end
      else
      begin
        compare("pix_y x2", 32'(pix_y), 32'(row_for(plot_pkg::X2_BASE_ROW, m_x2)));
        exp_col = (exp_col == plot_pkg::SCREEN_W - 1) ? 0 : exp_col + 1;
      end
      want_x2 = !want_x2;
      pix_count++;
    end
  end

  always @(negedge AnalogClock)
  begin
    if (UUT.u_checker.fail_cnt != 0)
    begin
      $display("an assertion in the bound checker failed before %0t ns", $time);
      $display("=== FAIL ===");
      $fatal(1, "assertion failed");
    end
  end

  always @(posedge AnalogClock)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "simulation timed out");
    end
  end

  initial
  begin
    logic [31:0] data;
    logic [1:0]  resp;
    arst_n    = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    pix_ready = 1'b0;
    m_x1      = '0;
    m_x2      = '0;
    m_v1      = '0;
    m_v2      = '0;
    repeat (16) @(posedge AnalogClock);
    @(negedge AnalogClock);
    arst_n = 1'b1;

    program_reg("REG_STEP_DIV", osc_pkg::REG_STEP_DIV, DIV);
    program_reg("REG_K1", osc_pkg::REG_K1, 32'(K1));
    program_reg("REG_K2", osc_pkg::REG_K2, 32'(K2));
    program_reg("REG_KMID", osc_pkg::REG_KMID, 32'(KMID));
    program_reg("REG_G1", osc_pkg::REG_G1, 32'(G1));
    program_reg("REG_G2", osc_pkg::REG_G2, 32'(G2));
    program_reg("REG_X1_INIT", osc_pkg::REG_X1_INIT, 32'(X1_INIT));
    program_reg("REG_X2_INIT", osc_pkg::REG_X2_INIT, 32'(X2_INIT));
    program_reg("REG_V1_INIT", osc_pkg::REG_V1_INIT, 32'(V1_INIT));
    program_reg("REG_V2_INIT", osc_pkg::REG_V2_INIT, 32'(V2_INIT));
    program_reg("REG_CTRL", osc_pkg::REG_CTRL, 32'd0);

    // partial word write leaves the register alone
    write_reg(osc_pkg::REG_K1, 32'h0000_1234, 4'b0011, resp);
    expect_reg("REG_K1", osc_pkg::REG_K1, 32'(K1));

    write_reg(BAD_ADDR, 32'hdead_beef, 4'hf, resp);
    compare("s_bresp", 32'(resp), 32'(osc_pkg::RESP_SLVERR));
    read_reg(BAD_ADDR, data, resp);
    compare("s_rresp", 32'(resp), 32'(osc_pkg::RESP_SLVERR));
    compare("s_rdata", data, 32'd0);

    write_reg(osc_pkg::REG_CTRL, 32'h2, 4'hf, resp);  // load
    m_x1 = X1_INIT;
    m_x2 = X2_INIT;
    m_v1 = V1_INIT;
    m_v2 = V2_INIT;
    expect_reg("REG_X1", osc_pkg::REG_X1, 32'(X1_INIT));
    expect_reg("REG_X2", osc_pkg::REG_X2, 32'(X2_INIT));
    expect_reg("REG_STEPS", osc_pkg::REG_STEPS, 32'd0);

    write_reg(osc_pkg::REG_CTRL, 32'h1, 4'hf, resp);  // run
    expect_reg("REG_CTRL", osc_pkg::REG_CTRL, 32'd1);
    while (pix_count < 2 * RUN_STEPS)
      @(negedge AnalogClock);
    write_reg(osc_pkg::REG_CTRL, 32'h0, 4'hf, resp);
    repeat (2) @(negedge AnalogClock);   // a last step may still be starting
    while (pix_valid)
      @(negedge AnalogClock);

    read_reg(osc_pkg::REG_STEPS, data, resp);
    compare("pix_count", 32'(pix_count), data << 1);
    expect_reg("REG_X1", osc_pkg::REG_X1, 32'(m_x1));
    expect_reg("REG_X2", osc_pkg::REG_X2, 32'(m_x2));

    if (err_cnt == 0 && UUT.u_checker.fail_cnt == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("=== FAIL ===");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
source/osc_pkg.sv
source/plot_pkg.sv
source/osc_axil_regs.sv
source/euler_integrator.sv
source/oscillator_core.sv
source/trace_plotter.sv
source/eulersillator_top.sv
verification/eulersillator_checker.sv
verification/eulersillator_tb.sv

// File: Bender.yml
package:
  name: eulersillator

sources:
  - source/osc_pkg.sv
  - source/plot_pkg.sv
  - source/osc_axil_regs.sv
  - source/euler_integrator.sv
  - source/oscillator_core.sv
  - source/trace_plotter.sv
  - source/eulersillator_top.sv
  - target: test
    files:
      - verification/eulersillator_checker.sv
      - verification/eulersillator_tb.sv
